//--- verilog/photon_pkg.sv
`default_nettype none

package photon_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths that carry a meaning.
    //////////////////////////////////////////////////////////////////////
    typedef logic [15:0] count_t;       // Photons in one frame, saturating.
    typedef logic [31:0] total_t;       // Running photon total, saturating.
    typedef logic [15:0] lcd_word_t;    // One word on the LCD data bus.

    // Stage requested from the writer.
    typedef enum logic [1:0] {
        DRAW_IDLE  = 2'd0,
        DRAW_FIXED = 2'd1,  // Background, once after reset.
        DRAW_FRAME = 2'd2,  // Latched frame count.
        DRAW_TOTAL = 2'd3   // Running total, two halves.
    } draw_stage_e;

    //////////////////////////////////////////////////////////////////////
    // LCD word codes.
    //////////////////////////////////////////////////////////////////////
    localparam lcd_word_t CMD_FIXED = 16'h00A1;
    localparam lcd_word_t CMD_FRAME = 16'h00A2;
    localparam lcd_word_t CMD_TOTAL = 16'h00A3;
    localparam lcd_word_t BG_COLOR  = 16'h001F;   // Blue.

    // Writer constants.
    localparam int FIXED_WORDS      = 4;   // Background words after CMD_FIXED.
    localparam int PANEL_RST_CYCLES = 8;   // lcd_rst low time.

    localparam int WORD_IDX_W = $clog2(FIXED_WORDS + 1);
    localparam int RST_CNT_W  = $clog2(PANEL_RST_CYCLES + 1);
    typedef logic [WORD_IDX_W-1:0] word_idx_t;   // Word within a stage.
    typedef logic [RST_CNT_W-1:0]  rst_cnt_t;    // Panel reset timer.

    // Test source periods at 80 MHz.
    localparam int PULSE_PERIOD_DEF = 800_000;     // 100 Hz.
    localparam int SYNC_PERIOD_DEF  = 1_600_000;   // 50 Hz.

endpackage

`default_nettype wire

//--- verilog/draw_if.sv
`default_nettype none

// Sequencer to writer link.
interface draw_if import photon_pkg::*; ();

    logic        en;      // Stage request, held until done.
    draw_stage_e stage;   // Stable while en is high.
    count_t      count;   // Latched frame count.
    logic        done;    // One cycle after the last word.

    modport seq (output en, output stage, output count, input done);
    modport wr  (input en, input stage, input count, output done);

endinterface

`default_nettype wire

//--- verilog/ext_signal_sync.sv
`default_nettype none

module ext_signal_sync (
    input  wire logic clk_80MHz,
    input  wire logic rst_n,
    input  wire logic sig_in,     // Asynchronous pin.
    output logic      sig_pulse   // One cycle per rising edge.
);

    logic sync_ff1;   // May go metastable.
    logic sync_ff2;
    logic level_d;    // Previous synced level.

    always_ff @(posedge clk_80MHz or negedge rst_n) begin
        if (!rst_n) begin
            sync_ff1 <= 1'b0;
            sync_ff2 <= 1'b0;
            level_d  <= 1'b0;
        end else begin
            sync_ff1 <= sig_in;
            sync_ff2 <= sync_ff1;
            level_d  <= sync_ff2;
        end
    end

    // Rising edge detect.
    assign sig_pulse = sync_ff2 & ~level_d;

endmodule

`default_nettype wire

//--- verilog/test_pulse_gen.sv
`default_nettype none

module test_pulse_gen import photon_pkg::*; #(
    parameter int PULSE_PERIOD = PULSE_PERIOD_DEF,
    parameter int SYNC_PERIOD  = SYNC_PERIOD_DEF
) (
    input  wire logic clk_80MHz,
    input  wire logic rst_n,
    output logic      test_pulse,   // Simulated photon.
    output logic      test_sync     // Simulated frame sync.
);

    logic [1:0] tick;   // Terminal count per divider.

    // Free-running wrap counters, index 0 photon, 1 sync.
    for (genvar g = 0; g < 2; g++) begin : g_div
        localparam int PERIOD = (g == 0) ? PULSE_PERIOD : SYNC_PERIOD;
        localparam int CNT_W  = $clog2(PERIOD);

        logic [CNT_W-1:0] cnt;

        always_ff @(posedge clk_80MHz or negedge rst_n) begin
            if (!rst_n) begin
                cnt <= '0;
            end else if (tick[g]) begin
                cnt <= '0;                  // Wrap.
            end else begin
                cnt <= cnt + CNT_W'(1);
            end
        end

        assign tick[g] = (cnt == CNT_W'(PERIOD - 1));
    end

    assign test_pulse = tick[0];
    assign test_sync  = tick[1];

endmodule

`default_nettype wire

//--- verilog/photon_counter.sv
`default_nettype none

module photon_counter import photon_pkg::*; (
    input  wire logic clk_80MHz,
    input  wire logic rst_n,
    input  wire logic photon,        // Synced photon pulse.
    input  wire logic frame_sync,    // Synced frame sync pulse.
    output count_t    frame_count,   // Count of the last full frame.
    output total_t    total          // Sum of all frames.
);

    count_t                 acc;         // Current frame.
    logic [$bits(total_t):0] total_sum;  // One carry bit for saturation.

    assign total_sum = ($bits(total_t) + 1)'(total) + ($bits(total_t) + 1)'(acc);

    //////////////////////////////////////////////////////////////////////
    // Frame accumulator and latch.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_80MHz or negedge rst_n) begin
        if (!rst_n) begin
            acc         <= '0;
            frame_count <= '0;
            total       <= '0;
        end else if (frame_sync) begin
            frame_count <= acc;
            // Coincident photon opens the new frame.
            acc <= photon ? count_t'(1) : '0;
            if (total_sum[$bits(total_t)]) begin
                total <= '1;                          // Saturate.
            end else begin
                total <= total_sum[$bits(total_t)-1:0];
            end
        end else if (photon && (acc != '1)) begin
            acc <= acc + count_t'(1);                 // Stops at max.
        end
    end

endmodule

`default_nettype wire

//--- verilog/screen_sequencer.sv
`default_nettype none

module screen_sequencer import photon_pkg::*; (
    input  wire logic   clk_80MHz,
    input  wire logic   rst_n,
    input  wire logic   frame_sync,
    input  wire count_t frame_count,
    output logic        busy,          // Counts being drawn.
    draw_if.seq         draw
);

    typedef enum logic [1:0] {
        ST_FIXED,
        ST_FRAME,
        ST_TOTAL,
        ST_WAIT_SYNC
    } seq_state_e;

    seq_state_e  state;
    logic        en_q;
    draw_stage_e stage_d;

    //////////////////////////////////////////////////////////////////////
    // Step machine.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_80MHz or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_FIXED;
            en_q  <= 1'b0;
        end else begin
            case (state)
                ST_FIXED: begin
                    if (draw.done) begin
                        en_q  <= 1'b0;
                        state <= ST_WAIT_SYNC;   // Background only once.
                    end else begin
                        en_q <= 1'b1;
                    end
                end
                ST_FRAME: begin
                    if (draw.done) begin
                        en_q  <= 1'b0;           // Low one cycle, writer rearms.
                        state <= ST_TOTAL;
                    end else begin
                        en_q <= 1'b1;
                    end
                end
                ST_TOTAL: begin
                    if (draw.done) begin
                        en_q  <= 1'b0;
                        state <= ST_WAIT_SYNC;
                    end else begin
                        en_q <= 1'b1;
                    end
                end
                default: begin
                    en_q <= 1'b0;
                    if (frame_sync) state <= ST_FRAME;   // Syncs while drawing are lost.
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            ST_FIXED: stage_d = DRAW_FIXED;
            ST_FRAME: stage_d = DRAW_FRAME;
            ST_TOTAL: stage_d = DRAW_TOTAL;
            default:  stage_d = DRAW_IDLE;
        endcase
    end

    assign draw.en    = en_q;
    assign draw.stage = stage_d;
    assign draw.count = frame_count;   // Writer samples at stage start.
    assign busy       = (state == ST_FRAME) || (state == ST_TOTAL);

endmodule

`default_nettype wire

//--- verilog/lcd_bus_writer.sv
`default_nettype none

module lcd_bus_writer import photon_pkg::*; (
    input  wire logic   clk_80MHz,
    input  wire logic   rst_n,
    input  wire total_t total,
    draw_if.wr          draw,
    output logic        lcd_rst,    // Panel reset, active low.
    output logic        bl_ctr,     // Backlight.
    output logic        lcd_cs,
    output logic        lcd_rs,     // 0 command, 1 data.
    output logic        lcd_wr,     // Data taken on rising edge.
    output lcd_word_t   lcd_data
);

    rst_cnt_t    rst_cnt;
    logic        armed;      // en seen low since last stage.
    logic        active;
    logic        phase;      // 0 wr low, 1 wr high.
    logic        done_q;
    draw_stage_e stage_r;
    word_idx_t   word_idx;
    word_idx_t   last_idx;
    logic        last_word;
    logic        start;
    count_t      count_r;
    total_t      total_r;

    // Word idx of a stage.
    function automatic lcd_word_t word_at(draw_stage_e stage, word_idx_t idx,
                                          count_t cnt, total_t tot);
        lcd_word_t w;
        w = BG_COLOR;
        if (idx == '0) begin
            case (stage)
                DRAW_FRAME: w = CMD_FRAME;
                DRAW_TOTAL: w = CMD_TOTAL;
                default:    w = CMD_FIXED;
            endcase
        end else begin
            case (stage)
                DRAW_FRAME: w = cnt;
                DRAW_TOTAL: w = (idx == word_idx_t'(1)) ? tot[31:16] : tot[15:0];
                default:    w = BG_COLOR;
            endcase
        end
        return w;
    endfunction

    always_comb begin
        case (stage_r)
            DRAW_FIXED: last_idx = word_idx_t'(FIXED_WORDS);
            DRAW_FRAME: last_idx = word_idx_t'(1);
            DRAW_TOTAL: last_idx = word_idx_t'(2);   // High then low half.
            default:    last_idx = '0;
        endcase
    end

    assign last_word = (word_idx == last_idx);
    assign start     = draw.en && armed && lcd_rst && !active;
    assign draw.done = done_q;

    //////////////////////////////////////////////////////////////////////
    // Panel reset timer.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_80MHz or negedge rst_n) begin
        if (!rst_n) begin
            rst_cnt <= '0;
            lcd_rst <= 1'b0;
        end else if (!lcd_rst) begin
            if (rst_cnt == rst_cnt_t'(PANEL_RST_CYCLES - 1)) lcd_rst <= 1'b1;
            rst_cnt <= rst_cnt + rst_cnt_t'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Word sequencing, two cycles per word.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_80MHz or negedge rst_n) begin
        if (!rst_n) begin
            armed    <= 1'b1;
            active   <= 1'b0;
            phase    <= 1'b0;
            done_q   <= 1'b0;
            stage_r  <= DRAW_IDLE;
            word_idx <= '0;
            lcd_cs   <= 1'b1;
            lcd_wr   <= 1'b1;
            lcd_rs   <= 1'b1;
            bl_ctr   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!draw.en) armed <= 1'b1;
            if (start) begin
                armed    <= 1'b0;
                active   <= 1'b1;
                stage_r  <= draw.stage;
                word_idx <= '0;
                phase    <= 1'b0;
                lcd_cs   <= 1'b0;            // Held low for the stage.
                lcd_wr   <= 1'b0;
                lcd_rs   <= 1'b0;            // Command word first.
            end else if (active) begin
                if (!phase) begin
                    lcd_wr <= 1'b1;
                    phase  <= 1'b1;
                end else if (last_word) begin
                    active <= 1'b0;
                    lcd_cs <= 1'b1;
                    done_q <= 1'b1;
                    if (stage_r == DRAW_FIXED) bl_ctr <= 1'b1;   // Screen ready.
                end else begin
                    word_idx <= word_idx + word_idx_t'(1);
                    lcd_wr   <= 1'b0;
                    lcd_rs   <= 1'b1;
                    phase    <= 1'b0;
                end
            end
        end
    end

    // Payload, captured at stage start.
    always_ff @(posedge clk_80MHz) begin
        if (start) begin
            count_r  <= draw.count;
            total_r  <= total;
            lcd_data <= word_at(draw.stage, '0, draw.count, total);
        end else if (active && phase && !last_word) begin
            lcd_data <= word_at(stage_r, word_idx + word_idx_t'(1), count_r, total_r);
        end
    end

endmodule

`default_nettype wire

//--- verilog/photon_counter_top.sv
`default_nettype none

module photon_counter_top import photon_pkg::*; #(
    parameter int PULSE_PERIOD = PULSE_PERIOD_DEF,
    parameter int SYNC_PERIOD  = SYNC_PERIOD_DEF
) (
    input  wire logic clk_80MHz,
    input  wire logic rst_n,
    input  wire logic photon_pulse,   // Detector pin.
    input  wire logic sync_50Hz,      // Frame sync pin.
    output logic      test_pulse,     // Loopback source for photon_pulse.
    output logic      test_sync,      // Loopback source for sync_50Hz.
    output logic      busy,
    output logic      lcd_rst,
    output logic      bl_ctr,
    output logic      lcd_cs,
    output logic      lcd_rs,
    output logic      lcd_wr,
    output lcd_word_t lcd_data
);

    logic   photon_sync;   // Synced photon edge.
    logic   frame_sync;    // Synced sync edge.
    count_t frame_count;
    total_t total;

    draw_if draw ();

    //////////////////////////////////////////////////////////////////////
    // Input synchronizers.
    //////////////////////////////////////////////////////////////////////
    ext_signal_sync u_photon_sync (
        .clk_80MHz (clk_80MHz),
        .rst_n     (rst_n),
        .sig_in    (photon_pulse),
        .sig_pulse (photon_sync)
    );

    ext_signal_sync u_frame_sync (
        .clk_80MHz (clk_80MHz),
        .rst_n     (rst_n),
        .sig_in    (sync_50Hz),
        .sig_pulse (frame_sync)
    );

    test_pulse_gen #(
        .PULSE_PERIOD (PULSE_PERIOD),
        .SYNC_PERIOD  (SYNC_PERIOD)
    ) u_test_gen (
        .clk_80MHz  (clk_80MHz),
        .rst_n      (rst_n),
        .test_pulse (test_pulse),
        .test_sync  (test_sync)
    );

    photon_counter u_counter (
        .clk_80MHz   (clk_80MHz),
        .rst_n       (rst_n),
        .photon      (photon_sync),
        .frame_sync  (frame_sync),
        .frame_count (frame_count),
        .total       (total)
    );

    //////////////////////////////////////////////////////////////////////
    // Display path.
    //////////////////////////////////////////////////////////////////////
    screen_sequencer u_sequencer (
        .clk_80MHz   (clk_80MHz),
        .rst_n       (rst_n),
        .frame_sync  (frame_sync),
        .frame_count (frame_count),
        .busy        (busy),
        .draw        (draw.seq)
    );

    lcd_bus_writer u_writer (
        .clk_80MHz (clk_80MHz),
        .rst_n     (rst_n),
        .total     (total),
        .draw      (draw.wr),
        .lcd_rst   (lcd_rst),
        .bl_ctr    (bl_ctr),
        .lcd_cs    (lcd_cs),
        .lcd_rs    (lcd_rs),
        .lcd_wr    (lcd_wr),
        .lcd_data  (lcd_data)
    );

endmodule

`default_nettype wire

//--- tb/photon_counter_sva.sv
`default_nettype none

module photon_counter_sva import photon_pkg::*; (
    input wire logic      clk_80MHz,
    input wire logic      rst_n,
    input wire logic      lcd_rst,
    input wire logic      lcd_cs,
    input wire logic      lcd_wr,
    input wire lcd_word_t lcd_data,
    input wire logic      en,     // Draw request.
    input wire logic      done    // Stage finished.
);

    int unsigned fail_count = 0;   // Failed assertions so far.

    //////////////////////////////////////////////////////////////////////
    // LCD bus strobe.
    //////////////////////////////////////////////////////////////////////
    wr_one_cycle: assert property (@(posedge clk_80MHz) disable iff (!rst_n)
        !lcd_wr |=> lcd_wr)
        else begin
            fail_count++;
            $error("lcd_wr low for more than one cycle");
        end

    data_stable: assert property (@(posedge clk_80MHz) disable iff (!rst_n)
        !lcd_wr |=> $stable(lcd_data))   // Held through the rising strobe.
        else begin
            fail_count++;
            $error("lcd_data changed while lcd_wr was low");
        end

    // Draw link.
    done_in_en: assert property (@(posedge clk_80MHz) disable iff (!rst_n)
        done |-> en)
        else begin
            fail_count++;
            $error("done pulsed without en");
        end

    cs_in_reset: assert property (@(posedge clk_80MHz) disable iff (!rst_n)
        !lcd_rst |-> lcd_cs)             // No select during panel reset.
        else begin
            fail_count++;
            $error("lcd_cs low while lcd_rst low");
        end

endmodule

bind lcd_bus_writer photon_counter_sva u_sva (
    .clk_80MHz (clk_80MHz),
    .rst_n     (rst_n),
    .lcd_rst   (lcd_rst),
    .lcd_cs    (lcd_cs),
    .lcd_wr    (lcd_wr),
    .lcd_data  (lcd_data),
    .en        (draw.en),
    .done      (draw.done)
);

`default_nettype wire

//--- tb/photon_counter_tb.sv
`default_nettype none

module photon_counter_tb import photon_pkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int DRV_DLY     = 2;            // Drive point after the edge.
    localparam int PULSE_P     = 50;
    localparam int SYNC_P      = 400;
    localparam int NUM_FRAMES  = 8;
    localparam int SAT_FRAME   = 3;            // Driven past the count limit.
    localparam int SAT_PHOTONS = 65536 + 100;
    localparam int SYNC_HIGH   = 3;
    localparam int EDGE_GUARD  = 8;            // Photon edges off sync edges.
    localparam int DRAIN_CYCLES    = 200;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * 700 + 2 * SAT_PHOTONS + 2000;

    // Test index.
    localparam int T_RESET    = 0;
    localparam int T_FIXED    = 1;
    localparam int T_FRAME    = 2;
    localparam int T_TOTAL    = 3;
    localparam int T_TEST_OUT = 4;
    localparam int T_BUSY     = 5;
    localparam int N_TESTS    = 6;

    // Kind of an expected LCD word.
    localparam int K_FIXED     = 0;
    localparam int K_FRAME_CMD = 1;
    localparam int K_COUNT     = 2;
    localparam int K_TOTAL_CMD = 3;
    localparam int K_TOTAL_HI  = 4;
    localparam int K_TOTAL_LO  = 5;

    logic      clk_80MHz;
    logic      rst_n;
    logic      photon_pulse;
    logic      sync_50Hz;
    logic      test_pulse;
    logic      test_sync;
    logic      busy;
    logic      lcd_rst;
    logic      bl_ctr;
    logic      lcd_cs;
    logic      lcd_rs;
    logic      lcd_wr;
    lcd_word_t lcd_data;

    logic [31:0] lfsr;
    int          errors [N_TESTS];
    int          checks [N_TESTS];
    count_t      model_frame;        // Photons in the open frame.
    total_t      model_total;
    int          exp_kind [$];       // Expected LCD words, in order.
    logic        exp_rs   [$];
    lcd_word_t   exp_word [$];
    lcd_word_t   hi_exp;
    lcd_word_t   hi_act;
    int          cyc_count;          // Cycles since reset release.
    int          last_pulse;
    int          last_sync;
    int          pulse_seen;
    int          sync_seen;
    int          sva_fails;
    int          total_err;
    int          total_chk;
    int          drain;

    photon_counter_top #(
        .PULSE_PERIOD (PULSE_P),
        .SYNC_PERIOD  (SYNC_P)
    ) uut (
        .clk_80MHz    (clk_80MHz),
        .rst_n        (rst_n),
        .photon_pulse (photon_pulse),
        .sync_50Hz    (sync_50Hz),
        .test_pulse   (test_pulse),
        .test_sync    (test_sync),
        .busy         (busy),
        .lcd_rst      (lcd_rst),
        .bl_ctr       (bl_ctr),
        .lcd_cs       (lcd_cs),
        .lcd_rs       (lcd_rs),
        .lcd_wr       (lcd_wr),
        .lcd_data     (lcd_data)
    );

    always #(CLK_PERIOD / 2) clk_80MHz = ~clk_80MHz;

    //////////////////////////////////////////////////////////////////////
    // Result checks and reports.
    //////////////////////////////////////////////////////////////////////
    function automatic string test_label(input int t);
        case (t)
            T_RESET:    return "reset_state";
            T_FIXED:    return "fixed_stage";
            T_FRAME:    return "frame_counts";
            T_TOTAL:    return "total";
            T_TEST_OUT: return "test_outputs";
            default:    return "busy";
        endcase
    endfunction

    task automatic word_check(input int t, input string what,
                              input lcd_word_t exp, input lcd_word_t act);
        checks[t]++;
        if (act !== exp) begin
            errors[t]++;
            $display("mismatch %s %s: expected %h actual %h", test_label(t), what, exp, act);
        end
    endtask

    task automatic count_check(input int t, input string what,
                               input count_t exp, input count_t act);
        checks[t]++;
        if (act !== exp) begin
            errors[t]++;
            $display("mismatch %s %s: expected %0d actual %0d", test_label(t), what, exp, act);
        end
    endtask

    task automatic total_check(input int t, input string what,
                               input total_t exp, input total_t act);
        checks[t]++;
        if (act !== exp) begin
            errors[t]++;
            $display("mismatch %s %s: expected %0d actual %0d", test_label(t), what, exp, act);
        end
    endtask

    task automatic flag_check(input int t, input string what, input logic exp, input logic act);
        checks[t]++;
        if (act !== exp) begin
            errors[t]++;
            $display("mismatch %s %s: expected %b actual %b", test_label(t), what, exp, act);
        end
    endtask

    task automatic spacing_check(input int t, input string what, input int exp, input int act);
        checks[t]++;
        if (act != exp) begin
            errors[t]++;
            $display("mismatch %s %s: expected %0d actual %0d", test_label(t), what, exp, act);
        end
    endtask

    task automatic note_failure(input int t, input string msg);
        errors[t]++;
        $display("%s: %s", test_label(t), msg);
    endtask

    task automatic report_test(input int t);
        $display("test %s: %s, %0d checks, %0d errors", test_label(t),
                 (errors[t] == 0) ? "ok" : "bad", checks[t], errors[t]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and model.
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1.
    endfunction

    task automatic draw_bits(input int n, output int v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);                       // One step per bit.
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_80MHz);
            #DRV_DLY;
        end
    endtask

    task automatic push_word(input int kind, input logic rs, input lcd_word_t w);
        exp_kind.push_back(kind);
        exp_rs.push_back(rs);
        exp_word.push_back(w);
    endtask

    // Sync edge, frame count and new total go to the display.
    task automatic close_frame();
        logic [32:0] sum;
        sum = {1'b0, model_total} + {17'd0, model_frame};
        model_total = sum[32] ? '1 : sum[31:0];           // Saturate.
        push_word(K_FRAME_CMD, 1'b0, CMD_FRAME);
        push_word(K_COUNT, 1'b1, model_frame);
        push_word(K_TOTAL_CMD, 1'b0, CMD_TOTAL);
        push_word(K_TOTAL_HI, 1'b1, model_total[31:16]);
        push_word(K_TOTAL_LO, 1'b1, model_total[15:0]);
        model_frame = '0;
    endtask

    task automatic send_photon(input int low_cycles, input int high_cycles);
        wait_cycles(low_cycles);
        photon_pulse = 1'b1;
        if (model_frame != '1) model_frame = model_frame + count_t'(1);
        wait_cycles(high_cycles);
        photon_pulse = 1'b0;
    endtask

    // One frame of photons up to the rising edge of the next sync.
    task automatic run_frame(input int f);
        int gap;
        int used;
        int lo;
        int hi;
        int v;
        if (f == SAT_FRAME) begin
            gap = 2 * EDGE_GUARD + 2 * SAT_PHOTONS;
        end else begin
            draw_bits(8, v);
            gap = 300 + v;                                // 300 to 555 cycles.
        end
        wait_cycles(SYNC_HIGH);
        sync_50Hz = 1'b0;
        wait_cycles(EDGE_GUARD - SYNC_HIGH);
        used = EDGE_GUARD;
        if (f == SAT_FRAME) begin
            repeat (SAT_PHOTONS) send_photon(1, 1);
            used += 2 * SAT_PHOTONS;
        end else begin
            draw_bits(3, lo);
            draw_bits(2, hi);
            while (used + lo + hi + 2 + EDGE_GUARD <= gap) begin
                send_photon(lo + 1, hi + 1);
                used += lo + hi + 2;
                draw_bits(3, lo);
                draw_bits(2, hi);
            end
        end
        wait_cycles(gap - used);
        flag_check(T_BUSY, "busy before sync", 1'b0, busy);
        if (f == 0) begin
            flag_check(T_FIXED, "bl_ctr", 1'b1, bl_ctr);
            if (exp_kind.size() != 0) note_failure(T_FIXED, "background words missing");
            report_test(T_RESET);
            report_test(T_FIXED);
        end
        close_frame();
        sync_50Hz = 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitor sampled at the rising clock edge.
    //////////////////////////////////////////////////////////////////////
    task automatic take_word(input logic rs, input lcd_word_t data);
        int        kind;
        int        t;
        logic      rs_exp;
        lcd_word_t w_exp;
        if (exp_kind.size() == 0) begin
            note_failure(T_FRAME, $sformatf("unexpected LCD write of %h", data));
            return;
        end
        kind   = exp_kind.pop_front();
        rs_exp = exp_rs.pop_front();
        w_exp  = exp_word.pop_front();
        t = (kind == K_FIXED) ? T_FIXED : (kind <= K_COUNT) ? T_FRAME : T_TOTAL;
        flag_check(t, "lcd_rs", rs_exp, rs);
        flag_check(t, "lcd_cs", 1'b0, lcd_cs);
        if (kind == K_FIXED) begin
            flag_check(T_RESET, "lcd_rst at write", 1'b1, lcd_rst);   // Panel out of reset.
        end
        case (kind)
            K_COUNT:    count_check(t, "frame count", count_t'(w_exp), count_t'(data));
            K_TOTAL_HI: begin
                hi_exp = w_exp;                           // Checked with the low half.
                hi_act = data;
            end
            K_TOTAL_LO: total_check(t, "total", {hi_exp, w_exp}, {hi_act, data});
            default:    word_check(t, "word", w_exp, data);
        endcase
        if (kind != K_FIXED) flag_check(T_BUSY, "busy at write", 1'b1, busy);
    endtask

    always @(posedge clk_80MHz) begin
        if (rst_n) begin
            if (!lcd_wr) take_word(lcd_rs, lcd_data);   // Strobe rises at this edge.
            cyc_count++;
            if (test_pulse) begin
                spacing_check(T_TEST_OUT, "test_pulse spacing", PULSE_P, cyc_count - last_pulse);
                last_pulse = cyc_count;
                pulse_seen++;
            end
            if (test_sync) begin
                spacing_check(T_TEST_OUT, "test_sync spacing", SYNC_P, cyc_count - last_sync);
                last_sync = cyc_count;
                sync_seen++;
            end
        end
    end

    // Watchdog.
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence.
    //////////////////////////////////////////////////////////////////////
    initial begin
        clk_80MHz    = 1'b0;
        rst_n        = 1'b0;
        photon_pulse = 1'b0;
        sync_50Hz    = 1'b0;
        lfsr         = 32'h1c80;
        model_frame  = '0;
        model_total  = '0;
        cyc_count    = 0;
        last_pulse   = 0;
        last_sync    = 0;
        pulse_seen   = 0;
        sync_seen    = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            errors[t] = 0;
            checks[t] = 0;
        end
        push_word(K_FIXED, 1'b0, CMD_FIXED);
        repeat (FIXED_WORDS) push_word(K_FIXED, 1'b1, BG_COLOR);

        wait_cycles(1);
        flag_check(T_RESET, "lcd_cs", 1'b1, lcd_cs);
        flag_check(T_RESET, "lcd_wr", 1'b1, lcd_wr);
        flag_check(T_RESET, "lcd_rs", 1'b1, lcd_rs);
        flag_check(T_RESET, "lcd_rst", 1'b0, lcd_rst);
        flag_check(T_RESET, "bl_ctr", 1'b0, bl_ctr);
        flag_check(T_RESET, "busy", 1'b0, busy);
        flag_check(T_RESET, "test_pulse", 1'b0, test_pulse);
        flag_check(T_RESET, "test_sync", 1'b0, test_sync);
        wait_cycles(1);
        rst_n = 1'b1;

        for (int f = 0; f < NUM_FRAMES; f++) run_frame(f);
        wait_cycles(SYNC_HIGH);
        sync_50Hz = 1'b0;

        // Last frame and total on the bus.
        drain = 0;
        while (exp_kind.size() != 0 && drain < DRAIN_CYCLES) begin
            wait_cycles(1);
            drain++;
        end
        if (exp_kind.size() != 0) note_failure(T_TOTAL, "display words still pending at the end");
        wait_cycles(50);
        flag_check(T_BUSY, "busy after drawing", 1'b0, busy);
        flag_check(T_TEST_OUT, "test_pulse seen", 1'b1, pulse_seen > 0);
        flag_check(T_TEST_OUT, "test_sync seen", 1'b1, sync_seen > 0);

        for (int t = T_FRAME; t < N_TESTS; t++) report_test(t);
        sva_fails = int'(uut.u_writer.u_sva.fail_count);
        if (sva_fails != 0) $display("%0d bound assertions failed", sva_fails);
        total_err = sva_fails;
        total_chk = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            total_err += errors[t];
            total_chk += checks[t];
        end
        $display("tests %0d, checks %0d, errors %0d", N_TESTS, total_chk, total_err);
        if (total_err == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/photon_pkg.sv
verilog/draw_if.sv
verilog/ext_signal_sync.sv
verilog/test_pulse_gen.sv
verilog/photon_counter.sv
verilog/screen_sequencer.sv
verilog/lcd_bus_writer.sv
verilog/photon_counter_top.sv
tb/photon_counter_sva.sv
tb/photon_counter_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= photon_counter_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= *** FAILED ***

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
